/* main_consts.svh */
/*
 * Shared constants for the main CPU bus glue
 * Bus widths, region codes on address bits 23:20,
 * I/O page selects on address bits 6:4 and motor travel limits
 */
`ifndef MAIN_CONSTS_SVH
`define MAIN_CONSTS_SVH

// Bus widths
`define ADDR_W 23           // Word address, bits 23:1
`define DATA_W 16

// Fixed region map, compared against cpu_addr[23:20]
`define REG_MEM 4'd0        // Program ROM and work RAM
`define REG_SCR 4'd1        // Tile and text RAM
`define REG_PAL 4'd2
`define REG_OBJ 4'd3
`define REG_IO  4'd4
`define REG_SUB 4'd5        // Sub CPU shared space

// I/O page selects, compared against cpu_addr[6:4]
`define IO_PPI 3'd0
`define IO_CAB 3'd1
`define IO_SND 3'd2
`define IO_ADC 3'd3
`define IO_OBJ 3'd7         // Object buffer swap strobe

// Motor position range
`define MOTOR_MIN   16'h1000
`define MOTOR_MAX   16'hF000
`define MOTOR_RESET 16'h8000  // Centre of travel

`endif

/* main_map_pkg.sv */
/*
 * Bus-side types
 * Region enum for the fixed address map and
 * the packed chip-select struct driven by the decoder
 */
package main_map_pkg;

    // One code per decoded region
    typedef enum logic [2:0] {
        RGN_MEM  = 3'd0,
        RGN_SCR  = 3'd1,
        RGN_PAL  = 3'd2,
        RGN_OBJ  = 3'd3,
        RGN_IO   = 3'd4,
        RGN_SUB  = 3'd5,
        RGN_NONE = 3'd7     // Anything unmapped
    } region_e;

    // Registered chip selects, at most one set per cycle
    typedef struct packed {
        logic rom;
        logic ram;
        logic char;     // Text layer RAM
        logic vram;     // Scroll tile RAM
        logic pal;
        logic obj;
        logic io;
        logic sub;
        logic none;
    } cs_t;

endpackage

/* cab_pkg.sv */
/*
 * Cabinet-side types
 * ADC channel numbering and the three 8255-style output ports
 */
package cab_pkg;

    // Channel picked by PPI port C bits 4:2
    typedef enum logic [2:0] {
        ADC_STEER = 3'd0,
        ADC_GAS   = 3'd1,
        ADC_BRAKE = 3'd2,
        ADC_MOTOR = 3'd3
    } adc_ch_e;

    // Output ports as seen by the cabinet
    typedef struct packed {
        logic [7:0] a;
        logic [7:0] b;  // Motor control
        logic [7:0] c;  // Object config, video enable, ADC channel, sound reset
    } ppi_ports_t;

endpackage

/* io_bus_if.sv */
/*
 * I/O page access from the bus decoder to the cabinet block
 * and the sound mailbox, with one read-data lane per target
 */
`timescale 1ns/1ps

interface io_bus_if;
    logic       sel;        // io_cs registered
    logic [2:0] page;
    logic [1:0] reg_sel;
    logic [7:0] wdata;
    logic       wr;         // First cycle of a write only
    logic [7:0] cab_rdata;
    logic [7:0] snd_rdata;

    modport src (
        output sel, page, reg_sel, wdata, wr,
        input  cab_rdata, snd_rdata
    );

    modport cab_tgt (input sel, page, reg_sel, wdata, wr, output cab_rdata);

    modport snd_tgt (input sel, page, reg_sel, wdata, wr, output snd_rdata);
endinterface

/* main_bus.sv */
/*
 * Main CPU bus decoder
 * Region decode on fixed address bits, registered chip selects,
 * I/O page access generation and the registered read-data return
 */
`timescale 1ns/1ps
`include "main_consts.svh"

module main_bus
    import main_map_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [`ADDR_W:1]   cpu_addr,
    input  logic [`DATA_W-1:0] cpu_dout,
    input  logic               rnw,
    input  logic [1:0]         dsn,
    input  logic               asn,
    input  logic [`DATA_W-1:0] ram_data,
    input  logic [`DATA_W-1:0] rom_data,
    input  logic [`DATA_W-1:0] char_dout,
    input  logic [`DATA_W-1:0] pal_dout,
    input  logic [`DATA_W-1:0] obj_dout,
    input  logic [`DATA_W-1:0] sub_din,
    output cs_t                cs,
    output logic [`DATA_W-1:0] cpu_din,
    io_bus_if.src              io
);
    logic       ds_any;     // Either data strobe low
    logic       bus_act;
    region_e    region;
    cs_t        cs_nx;
    logic       io_dly;     // io select seen last cycle
    logic [7:0] io_rdata;

    assign ds_any  = ~&dsn;
    assign bus_act = ~asn & (ds_any | rnw);

    always_comb begin
        case (cpu_addr[23:20])
            `REG_MEM: region = RGN_MEM;
            `REG_SCR: region = RGN_SCR;
            `REG_PAL: region = RGN_PAL;
            `REG_OBJ: region = RGN_OBJ;
            `REG_IO:  region = RGN_IO;
            `REG_SUB: region = RGN_SUB;
            default:  region = RGN_NONE;
        endcase
    end

    always_comb begin
        cs_nx = '0;
        if (bus_act) begin
            case (region)
                RGN_MEM: begin
                    // Work RAM sits in the top quarter of the region
                    cs_nx.rom = cpu_addr[18:17] != 2'b11;
                    cs_nx.ram = cpu_addr[18:17] == 2'b11 && ds_any;
                end
                RGN_SCR: begin
                    cs_nx.char = cpu_addr[16];
                    cs_nx.vram = !cpu_addr[16] && ds_any;
                end
                RGN_PAL: cs_nx.pal = 1'b1;
                RGN_OBJ: cs_nx.obj = 1'b1;
                RGN_IO:  cs_nx.io  = 1'b1;
                RGN_SUB: cs_nx.sub = 1'b1;
                default: cs_nx.none = 1'b1;
            endcase
        end
    end

    // Selects follow the strobes by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs     <= '0;
            io_dly <= 1'b0;
        end else begin
            cs     <= cs_nx;
            io_dly <= cs.io;
        end
    end

    assign io.sel     = cs.io;
    assign io.page    = cpu_addr[6:4];
    assign io.reg_sel = cpu_addr[2:1];
    assign io.wdata   = cpu_dout[7:0];
    assign io.wr      = cs.io & ~io_dly & ~rnw & ~dsn[0];    // Low byte lane only

    assign io_rdata = (io.page == `IO_SND) ? io.snd_rdata : io.cab_rdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= '0;
        end else begin
            if (cs.ram || cs.vram)
                cpu_din <= ram_data;
            else if (cs.rom)
                cpu_din <= rom_data;
            else if (cs.char)
                cpu_din <= char_dout;
            else if (cs.pal)
                cpu_din <= pal_dout;
            else if (cs.obj)
                cpu_din <= obj_dout;
            else if (cs.sub)
                cpu_din <= sub_din;
            else if (cs.io)
                cpu_din <= {8'hFF, io_rdata};
            else
                cpu_din <= 16'hFFFF;    // Open bus, also for none
        end
    end

    // Region decode must never overlap
    a_cs_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(cs));

endmodule

/* cab_io.sv */
/*
 * Cabinet I/O page
 * 8255-style output port registers, switch and DIP reads,
 * ADC channel mux and the object buffer toggle strobe
 */
`timescale 1ns/1ps
`include "main_consts.svh"

module cab_io
    import cab_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  joystick1,
    input  logic [15:0] joyana1,
    input  logic [15:0] joyana1b,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic        dip_test,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [15:0] motor_pos,
    output ppi_ports_t  ports,
    output logic        obj_toggle,
    io_bus_if.cab_tgt   io
);
    adc_ch_e    adc_ch;
    logic [7:0] adc_dout;
    logic [7:0] ppi_dout;
    logic [7:0] sw_dout;
    logic [7:0] pedal;      // Shared pedal scaling

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ports <= '0;
        end else if (io.wr && io.page == `IO_PPI) begin
            case (io.reg_sel)
                2'd0: ports.a <= io.wdata;
                2'd1: ports.b <= io.wdata;
                2'd2: ports.c <= io.wdata;
                default: ;  // Mode register not kept
            endcase
        end
    end

    always_comb begin
        case (io.reg_sel)
            2'd0:    ppi_dout = ports.a;
            2'd1:    ppi_dout = ports.b;
            2'd2:    ppi_dout = ports.c;
            default: ppi_dout = 8'hFF;
        endcase
    end

    always_comb begin
        case (io.reg_sel)
            2'd0: sw_dout = {coin_input, ~joystick1[4], joystick1[4],
                             start_button[0], service, dip_test, 1'b1};
            2'd1: sw_dout = 8'hFF;
            2'd2: sw_dout = dipsw_a;
            default: sw_dout = dipsw_b;
        endcase
    end

    assign adc_ch = adc_ch_e'(ports.c[4:2]);
    assign pedal  = {joyana1b[14:8], joyana1b[14]};    // Sign bit picks gas or brake

    always_comb begin
        case (adc_ch)
            ADC_STEER: adc_dout = !joystick1[0] ? 8'hD0 :
                                  !joystick1[1] ? 8'h20 :
                                  joyana1[7:0] ^ 8'h80;
            ADC_GAS:   adc_dout = !joystick1[3] ? 8'hF0 :
                                  joyana1b[15]  ? ~pedal : 8'h00;
            ADC_BRAKE: adc_dout = !joystick1[2] ? 8'hF0 :
                                  joyana1b[15]  ? 8'h00 : pedal;
            ADC_MOTOR: adc_dout = motor_pos[15:8];
            default:   adc_dout = 8'hFF;
        endcase
    end

    always_comb begin
        case (io.page)
            `IO_PPI: io.cab_rdata = ppi_dout;
            `IO_CAB: io.cab_rdata = sw_dout;
            `IO_ADC: io.cab_rdata = adc_dout;
            default: io.cab_rdata = 8'hFF;
        endcase
    end

    // Held for the whole access
    assign obj_toggle = io.sel && io.page == `IO_OBJ;

    // Decoder only writes inside a selected I/O cycle
    a_wr_in_sel: assert property (@(posedge clk) disable iff (rst) io.wr |-> io.sel);

endmodule

/* motor_pos.sv */
/*
 * Motor position tracker
 * Steps once per vint rising edge by the speed in ctrl[2:0],
 * direction from ctrl[3], saturating at the travel limits
 */
`timescale 1ns/1ps
`include "main_consts.svh"

module motor_pos (
    input  logic        clk,
    input  logic        rst,
    input  logic        vint,
    input  logic [7:0]  ctrl,
    output logic [15:0] pos
);
    logic        vint_q;
    logic        vint_rise;
    logic [16:0] step;      // Speed times 256
    logic [16:0] up_pos;
    logic [16:0] dn_floor;  // Lowest pos that can take a full step down
    logic [15:0] next_pos;

    assign vint_rise = vint & ~vint_q;
    assign step      = {6'd0, ctrl[2:0], 8'd0};
    assign up_pos    = {1'b0, pos} + step;
    assign dn_floor  = {1'b0, `MOTOR_MIN} + step;

    always_comb begin
        if (ctrl[3])
            next_pos = (up_pos > {1'b0, `MOTOR_MAX}) ? `MOTOR_MAX : up_pos[15:0];
        else
            next_pos = ({1'b0, pos} < dn_floor) ? `MOTOR_MIN : pos - step[15:0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vint_q <= 1'b0;
            pos    <= `MOTOR_RESET;
        end else begin
            vint_q <= vint;
            if (vint_rise)
                pos <= next_pos;    // Once per frame
        end
    end

    a_pos_range: assert property (@(posedge clk) disable iff (rst)
        pos >= `MOTOR_MIN && pos <= `MOTOR_MAX);

endmodule

/* snd_mailbox.sv */
/*
 * Sound mailbox
 * Main-to-sound command byte with buffer-full flag,
 * and a reply byte written by the sound CPU for the main side
 */
`timescale 1ns/1ps
`include "main_consts.svh"

module snd_mailbox (
    input  logic       clk,
    input  logic       rst,
    input  logic       sndmap_rd,
    input  logic       sndmap_wr,
    input  logic [7:0] sndmap_din,
    output logic [7:0] sndmap_dout,
    output logic       sndmap_pbf,
    io_bus_if.snd_tgt  io
);
    logic       main_wr;
    logic [7:0] reply;

    assign main_wr = io.wr && io.page == `IO_SND;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sndmap_dout <= 8'h00;
            sndmap_pbf  <= 1'b0;
        end else begin
            if (main_wr) begin
                sndmap_dout <= io.wdata;    // Overwrites even when full
                sndmap_pbf  <= 1'b1;
            end else if (sndmap_rd) begin
                sndmap_pbf  <= 1'b0;
            end
        end
    end

    // Sound CPU answer
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            reply <= 8'h00;
        else if (sndmap_wr)
            reply <= sndmap_din;
    end

    assign io.snd_rdata = reply;

    // Flag may only rise from a main CPU write
    a_pbf_src: assert property (@(posedge clk) disable iff (rst)
        $rose(sndmap_pbf) |-> $past(main_wr));

endmodule

/* main_top.sv */
/*
 * Main CPU bus glue top level
 * Bus decoder, cabinet I/O, motor tracker and sound mailbox
 */
`timescale 1ns/1ps
`include "main_consts.svh"

module main_top
    import main_map_pkg::*;
    import cab_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    // CPU bus
    input  logic [`ADDR_W:1]   cpu_addr,
    input  logic [`DATA_W-1:0] cpu_dout,
    input  logic               rnw,
    input  logic [1:0]         cpu_dsn,
    input  logic               asn,
    output logic [`DATA_W-1:0] cpu_din,
    output logic [19:1]        addr,
    output logic [1:0]         dsn,
    // Memory and video data
    input  logic [`DATA_W-1:0] ram_data,
    input  logic [`DATA_W-1:0] rom_data,
    input  logic [`DATA_W-1:0] char_dout,
    input  logic [`DATA_W-1:0] pal_dout,
    input  logic [`DATA_W-1:0] obj_dout,
    input  logic [`DATA_W-1:0] sub_din,
    output logic               rom_cs,
    output logic               ram_cs,
    output logic               char_cs,
    output logic               vram_cs,
    output logic               pal_cs,
    output logic               objram_cs,
    output logic               sub_cs,
    // Cabinet
    input  logic [7:0]         joystick1,
    input  logic [15:0]        joyana1,
    input  logic [15:0]        joyana1b,
    input  logic [1:0]         start_button,
    input  logic [1:0]         coin_input,
    input  logic               service,
    input  logic               dip_test,
    input  logic [7:0]         dipsw_a,
    input  logic [7:0]         dipsw_b,
    input  logic               vint,
    output logic [1:0]         obj_cfg,
    output logic               video_en,
    output logic               snd_rstb,
    output logic               obj_toggle,
    // Sound CPU side
    input  logic               sndmap_rd,
    input  logic               sndmap_wr,
    input  logic [7:0]         sndmap_din,
    output logic [7:0]         sndmap_dout,
    output logic               sndmap_pbf
);
    cs_t         cs;
    ppi_ports_t  ports;
    logic [15:0] mpos;

    io_bus_if io_bus();

    assign addr      = cpu_addr[19:1];
    assign dsn       = cpu_dsn;
    assign rom_cs    = cs.rom;
    assign ram_cs    = cs.ram;
    assign char_cs   = cs.char;
    assign vram_cs   = cs.vram;
    assign pal_cs    = cs.pal;
    assign objram_cs = cs.obj;
    assign sub_cs    = cs.sub;
    assign obj_cfg   = ports.c[7:6];
    assign video_en  = ports.c[5];
    assign snd_rstb  = ports.c[0];  // Sound CPU held in reset while low

    main_bus u_bus (
        .clk(clk), .rst(rst),
        .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
        .rnw(rnw), .dsn(cpu_dsn), .asn(asn),
        .ram_data(ram_data), .rom_data(rom_data), .char_dout(char_dout),
        .pal_dout(pal_dout), .obj_dout(obj_dout), .sub_din(sub_din),
        .cs(cs), .cpu_din(cpu_din), .io(io_bus.src)
    );

    cab_io u_cab (
        .clk(clk), .rst(rst),
        .joystick1(joystick1), .joyana1(joyana1), .joyana1b(joyana1b),
        .start_button(start_button), .coin_input(coin_input),
        .service(service), .dip_test(dip_test),
        .dipsw_a(dipsw_a), .dipsw_b(dipsw_b), .motor_pos(mpos),
        .ports(ports), .obj_toggle(obj_toggle), .io(io_bus.cab_tgt)
    );

    motor_pos u_motor (
        .clk(clk), .rst(rst), .vint(vint), .ctrl(ports.b), .pos(mpos)
    );

    snd_mailbox u_mailbox (
        .clk(clk), .rst(rst),
        .sndmap_rd(sndmap_rd), .sndmap_wr(sndmap_wr), .sndmap_din(sndmap_din),
        .sndmap_dout(sndmap_dout), .sndmap_pbf(sndmap_pbf), .io(io_bus.snd_tgt)
    );

endmodule

/* tb_main_top.sv */
/*
 * Testbench for the main CPU bus glue
 * Random bus cycles over the fixed region map, random cabinet and
 * sound-side stimulus, directed ADC channel and motor travel sweeps,
 * a reference model of the PPI ports, motor tracker and mailbox,
 * and checks of selects, read data and outputs
 */
`timescale 1ns/1ps
`include "main_consts.svh"

module tb_main_top;
    localparam int N_ACC        = 600;
    localparam int ACC_CYCLES   = 4;    // 3 active plus 1 idle
    localparam int N_ADC_RD     = 8;    // Reads per ADC channel
    localparam int MOTOR_FRAMES = 80;   // Half up, half down
    localparam int N_DIRECTED   = 8 * (N_ADC_RD + 1) + MOTOR_FRAMES * 10 + 4;
    localparam int MAX_CYCLES   = (N_ACC + N_DIRECTED) * ACC_CYCLES + 200;

    // Bit order of the select vector {rom, ram, char, vram, pal, obj, sub}
    localparam int S_ROM  = 6;
    localparam int S_RAM  = 5;
    localparam int S_CHAR = 4;
    localparam int S_VRAM = 3;
    localparam int S_PAL  = 2;
    localparam int S_OBJ  = 1;
    localparam int S_SUB  = 0;

    logic               clk;
    logic               rst;
    logic [`ADDR_W:1]   cpu_addr;
    logic [`DATA_W-1:0] cpu_dout;
    logic               rnw;
    logic [1:0]         cpu_dsn;
    logic               asn;
    logic [`DATA_W-1:0] cpu_din;
    logic [19:1]        addr;
    logic [1:0]         dsn;
    logic [`DATA_W-1:0] ram_data, rom_data, char_dout, pal_dout, obj_dout, sub_din;
    logic               rom_cs, ram_cs, char_cs, vram_cs, pal_cs, objram_cs, sub_cs;
    logic [7:0]         joystick1;
    logic [15:0]        joyana1;
    logic [15:0]        joyana1b;
    logic [1:0]         start_button;
    logic [1:0]         coin_input;
    logic               service;
    logic               dip_test;
    logic [7:0]         dipsw_a;
    logic [7:0]         dipsw_b;
    logic               vint;
    logic [1:0]         obj_cfg;
    logic               video_en;
    logic               snd_rstb;
    logic               obj_toggle;
    logic               sndmap_rd;
    logic               sndmap_wr;
    logic [7:0]         sndmap_din;
    logic [7:0]         sndmap_dout;
    logic               sndmap_pbf;

    // Reference model state
    logic [7:0]  m_port [0:2];  // PPI ports a, b, c
    logic [15:0] m_pos;
    logic        m_pbf;
    logic [7:0]  m_snd;
    logic [7:0]  m_reply;
    int          cycles = 0;

    main_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    function automatic logic [7:0] cab_expect(input logic [1:0] rs);
        case (rs)
            2'd0: return {coin_input, ~joystick1[4], joystick1[4],
                          start_button[0], service, dip_test, 1'b1};
            2'd1: return 8'hFF;
            2'd2: return dipsw_a;
            default: return dipsw_b;
        endcase
    endfunction

    function automatic logic [7:0] adc_expect();
        logic [7:0] pedal;
        pedal = {joyana1b[14:8], joyana1b[14]};
        case (m_port[2][4:2])
            3'd0: begin
                if (!joystick1[0])
                    return 8'hD0;
                else if (!joystick1[1])
                    return 8'h20;
                return {~joyana1[7], joyana1[6:0]};
            end
            3'd1: begin
                if (!joystick1[3])
                    return 8'hF0;
                return joyana1b[15] ? ~pedal : 8'h00;   // Gas on the negative half
            end
            3'd2: begin
                if (!joystick1[2])
                    return 8'hF0;
                return joyana1b[15] ? 8'h00 : pedal;
            end
            3'd3: return m_pos[15:8];
            default: return 8'hFF;
        endcase
    endfunction

    function automatic logic [7:0] io_expect(input logic [2:0] page, input logic [1:0] rs);
        case (page)
            `IO_PPI: return (rs == 2'd3) ? 8'hFF : m_port[rs];
            `IO_CAB: return cab_expect(rs);
            `IO_SND: return m_reply;
            `IO_ADC: return adc_expect();
            default: return 8'hFF;
        endcase
    endfunction

    function automatic logic [23:1] make_io_addr(input logic [2:0] page, input logic [1:0] rs);
        return {`REG_IO, 13'($urandom), page, 1'($urandom), rs};
    endfunction

    function automatic logic [2:0] pick_page();
        case ($urandom % 8)
            0, 1:    return `IO_PPI;
            2:       return `IO_CAB;
            3:       return `IO_SND;
            4, 5:    return `IO_ADC;
            6:       return `IO_OBJ;
            default: return 3'($urandom);
        endcase
    endfunction

    // Frame step of the motor model, saturating at the travel limits
    task automatic step_motor();
        int p;
        int step;
        p    = int'(m_pos);
        step = int'(m_port[1][2:0]) * 256;
        if (m_port[1][3])
            p = (p + step > int'(`MOTOR_MAX)) ? int'(`MOTOR_MAX) : p + step;
        else
            p = (p - step < int'(`MOTOR_MIN)) ? int'(`MOTOR_MIN) : p - step;
        m_pos = 16'(p);
    endtask

    task automatic shuffle_inputs();
        ram_data     <= 16'($urandom);
        rom_data     <= 16'($urandom);
        char_dout    <= 16'($urandom);
        pal_dout     <= 16'($urandom);
        obj_dout     <= 16'($urandom);
        sub_din      <= 16'($urandom);
        joystick1    <= 8'($urandom);
        joyana1      <= 16'($urandom);
        joyana1b     <= 16'($urandom);
        start_button <= 2'($urandom);
        coin_input   <= 2'($urandom);
        service      <= 1'($urandom);
        dip_test     <= 1'($urandom);
        dipsw_a      <= 8'($urandom);
        dipsw_b      <= 8'($urandom);
    endtask

    // One bus access of 3 active cycles that returns on the edge ending it
    task automatic run_access(input logic [23:1] a, input logic r, input logic [1:0] ds,
                              input logic [15:0] wd);
        logic        ds_any;
        logic        active;
        logic [6:0]  e_sel;
        logic        e_io;
        logic [15:0] rd_exp;
        @(posedge clk);
        cpu_addr  <= a;
        rnw       <= r;
        cpu_dsn   <= ds;
        cpu_dout  <= wd;
        asn       <= 1'b0;
        vint      <= 1'b0;
        sndmap_rd <= 1'b0;
        sndmap_wr <= 1'b0;
        ds_any = (ds != 2'b11);
        active = ds_any || r;
        e_sel  = '0;
        e_io   = 1'b0;
        rd_exp = 16'hFFFF;
        if (active) begin
            case (a[23:20])
                `REG_MEM: begin
                    if (a[18:17] != 2'b11) begin
                        e_sel[S_ROM] = 1'b1;
                        rd_exp = rom_data;
                    end else if (ds_any) begin
                        e_sel[S_RAM] = 1'b1;
                        rd_exp = ram_data;
                    end
                end
                `REG_SCR: begin
                    if (a[16]) begin
                        e_sel[S_CHAR] = 1'b1;
                        rd_exp = char_dout;
                    end else if (ds_any) begin
                        e_sel[S_VRAM] = 1'b1;
                        rd_exp = ram_data;  // Tile RAM shares the RAM data bus
                    end
                end
                `REG_PAL: begin
                    e_sel[S_PAL] = 1'b1;
                    rd_exp = pal_dout;
                end
                `REG_OBJ: begin
                    e_sel[S_OBJ] = 1'b1;
                    rd_exp = obj_dout;
                end
                `REG_IO: begin
                    e_io   = 1'b1;
                    rd_exp = {8'hFF, io_expect(a[6:4], a[2:1])};
                end
                `REG_SUB: begin
                    e_sel[S_SUB] = 1'b1;
                    rd_exp = sub_din;
                end
                default: ;
            endcase
        end

        @(posedge clk);
        @(negedge clk);
        check_eq("chip selects", 32'({rom_cs, ram_cs, char_cs, vram_cs, pal_cs,
                                      objram_cs, sub_cs}), 32'(e_sel));
        check_eq("obj_toggle", 32'(obj_toggle), 32'(e_io && a[6:4] == `IO_OBJ));
        check_eq("addr", 32'(addr), 32'(a[19:1]));
        check_eq("dsn", 32'(dsn), 32'(ds));

        @(posedge clk);
        @(negedge clk);
        check_eq("cpu_din", 32'(cpu_din), 32'(rd_exp));
        if (e_io && !r && !ds[0]) begin
            if (a[6:4] == `IO_PPI && a[2:1] != 2'd3)
                m_port[a[2:1]] = wd[7:0];
            if (a[6:4] == `IO_SND) begin
                m_snd = wd[7:0];
                m_pbf = 1'b1;
            end
        end
        check_eq("obj_cfg", 32'(obj_cfg), 32'(m_port[2][7:6]));
        check_eq("video_en", 32'(video_en), 32'(m_port[2][5]));
        check_eq("snd_rstb", 32'(snd_rstb), 32'(m_port[2][0]));
        check_eq("sndmap_pbf", 32'(sndmap_pbf), 32'(m_pbf));
        check_eq("sndmap_dout", 32'(sndmap_dout), 32'(m_snd));

        @(posedge clk);
        asn     <= 1'b1;
        cpu_dsn <= 2'b11;
        rnw     <= 1'b1;
    endtask

    task automatic random_access();
        logic [23:1] a;
        int          pick;
        pick = int'($urandom % 12);
        a    = 23'($urandom);
        if (pick < 6)
            a[23:20] = 4'(pick);
        else if (pick < 10)
            a = make_io_addr(pick_page(), 2'($urandom));  // I/O page favoured
        else
            a[23:20] = 4'(6 + $urandom % 10);
        run_access(a, 1'($urandom), 2'($urandom), 16'($urandom));
    endtask

    // Sound CPU activity in the idle cycle
    task automatic sound_side();
        logic [7:0] d;
        d = 8'($urandom);
        case ($urandom % 8)
            0: begin
                sndmap_rd <= 1'b1;
                m_pbf = 1'b0;
            end
            1: begin
                sndmap_wr  <= 1'b1;
                sndmap_din <= d;
                m_reply = d;
            end
            default: ;
        endcase
    endtask

    // Each ADC channel in turn under fresh cabinet inputs
    task automatic adc_sweep();
        for (int ch = 0; ch < 8; ch++) begin
            run_access(make_io_addr(`IO_PPI, 2'd2), 1'b0, 2'b10,
                       {8'h00, 3'($urandom), 3'(ch), 2'($urandom)});
            for (int k = 0; k < N_ADC_RD; k++) begin
                shuffle_inputs();
                run_access(make_io_addr(`IO_ADC, 2'($urandom)), 1'b1, 2'b00, 16'h0000);
            end
        end
    endtask

    // Motor pushed to both travel limits and read back through the ADC
    task automatic motor_sweep();
        logic [15:0] ctrl;
        run_access(make_io_addr(`IO_PPI, 2'd2), 1'b0, 2'b00, 16'h000C);   // Motor channel
        for (int f = 0; f < MOTOR_FRAMES; f++) begin
            ctrl = {8'h00, 4'($urandom), 1'(f < MOTOR_FRAMES / 2), 2'b11, 1'($urandom)};
            run_access(make_io_addr(`IO_PPI, 2'd1), 1'b0, 2'b00, ctrl);
            for (int k = 0; k < 9; k++)
                run_access(make_io_addr(`IO_ADC, 2'($urandom)), 1'b1, 2'b00, 16'h0000);
            vint <= 1'b1;   // Ten accesses per frame
            step_motor();
        end
    endtask

    initial begin
        void'($urandom(32'h0074_b502));
        rst        = 1'b1;
        cpu_addr   = '0;
        cpu_dout   = '0;
        rnw        = 1'b1;
        cpu_dsn    = 2'b11;
        asn        = 1'b1;
        vint       = 1'b0;
        sndmap_rd  = 1'b0;
        sndmap_wr  = 1'b0;
        sndmap_din = 8'h00;
        m_port[0]  = 8'h00;
        m_port[1]  = 8'h00;
        m_port[2]  = 8'h00;
        m_pos      = `MOTOR_RESET;
        m_pbf      = 1'b0;
        m_snd      = 8'h00;
        m_reply    = 8'h00;
        shuffle_inputs();

        repeat (7) @(posedge clk);
        @(negedge clk);
        check_eq("chip selects in reset", 32'({rom_cs, ram_cs, char_cs, vram_cs, pal_cs,
                                               objram_cs, sub_cs}), 32'd0);
        check_eq("obj_toggle in reset", 32'(obj_toggle), 32'd0);
        check_eq("sndmap_pbf in reset", 32'(sndmap_pbf), 32'd0);
        check_eq("video_en in reset", 32'(video_en), 32'd0);
        check_eq("snd_rstb in reset", 32'(snd_rstb), 32'd0);
        check_eq("cpu_din in reset", 32'(cpu_din), 32'd0);
        @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < N_ACC; i++) begin
            random_access();
            shuffle_inputs();
            if (i % 10 == 9) begin
                vint <= 1'b1;   // One frame every 40 cycles
                step_motor();
            end
            sound_side();
        end

        adc_sweep();
        motor_sweep();

        // Mailbox overwrite while full, then a sound read and a reply
        run_access(make_io_addr(`IO_SND, 2'd0), 1'b0, 2'b00, 16'h0011);
        run_access(make_io_addr(`IO_SND, 2'd0), 1'b0, 2'b00, 16'h00A5);
        sndmap_rd <= 1'b1;
        m_pbf = 1'b0;
        @(posedge clk);
        sndmap_rd <= 1'b0;
        @(negedge clk);
        check_eq("sndmap_pbf after read", 32'(sndmap_pbf), 32'd0);
        @(posedge clk);
        sndmap_wr  <= 1'b1;
        sndmap_din <= 8'h5A;
        m_reply = 8'h5A;
        run_access(make_io_addr(`IO_SND, 2'd1), 1'b1, 2'b00, 16'h0000);

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* sources.f */
+incdir+.
main_map_pkg.sv
cab_pkg.sv
io_bus_if.sv
main_bus.sv
cab_io.sv
motor_pos.sv
snd_mailbox.sv
main_top.sv
tb_main_top.sv

/* run.sh */
#!/bin/sh
# Build and run the main_top testbench with Verilator
set -e

verilator --binary --timing --assert -j 0 --top-module tb_main_top \
    -f sources.f -o sim_main_top

./obj_dir/sim_main_top > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
